//--- controlUnit_trace.txt
# opcode funct GT LT ET O Div0 | cycles regWrites lastRegData lastPCsrc EPCwrites MemWRs
# opcode/funct in hex, flags and codes in binary, counts in decimal; cycles 0 marks the final break
00 20 0 0 0 0 0   6 1 0010 000 0 0   add
00 22 0 0 0 0 0   6 1 0010 000 0 0   sub
00 24 0 0 0 0 0   6 1 0010 000 0 0   and
00 2a 0 1 0 0 0   6 1 0010 000 0 0   slt
08 00 0 0 0 0 0   6 1 0010 000 0 0   addi
09 00 0 0 0 1 0   6 1 0010 000 0 0   addiu ignores overflow
0a 00 0 0 0 0 0   6 1 0010 000 0 0   slti
04 00 0 0 1 0 0   6 0 0000 001 0 0   beq taken
04 00 0 1 0 0 0   5 0 0000 000 0 0   beq not taken
05 00 1 0 0 0 0   6 0 0000 001 0 0   bne taken
05 00 0 0 1 0 0   5 0 0000 000 0 0   bne not taken
07 00 1 0 0 0 0   6 0 0000 001 0 0   bgt taken
07 00 0 1 0 0 0   5 0 0000 000 0 0   bgt not taken
06 00 0 1 0 0 0   6 0 0000 001 0 0   ble taken on less
06 00 0 0 1 0 0   6 0 0000 001 0 0   ble taken on equal
06 00 1 0 0 0 0   5 0 0000 000 0 0   ble not taken
23 00 0 0 0 0 0   9 1 0001 000 0 0   lw
2b 00 0 0 0 0 0   6 0 0000 000 0 1   sw
02 00 0 0 0 0 0   5 0 0000 010 0 0   j
03 00 0 0 0 0 0   6 1 0010 010 0 0   jal
00 08 0 0 0 0 0   5 0 0000 000 0 0   jr
0f 00 0 0 0 0 0   5 1 1000 000 0 0   lui
00 10 0 0 0 0 0   5 1 0011 000 0 0   mfhi
00 12 0 0 0 0 0   5 1 0100 000 0 0   mflo
00 13 0 0 0 0 0   5 0 0000 011 0 0   rte
00 18 0 0 0 0 0  38 0 0000 000 0 0   mult
00 1a 0 0 0 0 0  38 0 0000 000 0 0   div
00 20 0 0 0 1 0  11 0 0000 100 1 0   add overflow
00 22 0 0 0 1 0  11 0 0000 100 1 0   sub overflow
08 00 0 0 0 1 0  11 0 0000 100 1 0   addi overflow
00 1a 0 0 0 0 1  11 0 0000 100 1 0   div by zero
3f 00 0 0 0 0 0  10 0 0000 100 1 0   unknown opcode
00 3f 0 0 0 0 0  10 0 0000 100 1 0   unknown funct
00 0d 0 0 0 0 0   0 0 0000 000 0 0   break

//--- sim.f
+incdir+.
cuPkg.sv
decodeIf.sv
instrDecoder.sv
stateSequencer.sv
controlEncoder.sv
controlUnit.sv
controlUnit_asserts.sv
controlUnit_tb.sv

//--- run.sh
#!/bin/sh
# build and run the control unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module controlUnit_tb -f sim.f -o controlUnitSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/controlUnitSim +verilator+error+limit+1000)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "PASS: all tests"; then
    exit 0
fi
exit 1

//--- controlUnit_tb.sv
`timescale 1ns/100ps
`include "cuCfg_cfg.svh"

module controlUnit_tb;

    localparam int clockPeriod   = 4;
    localparam int resetCycles   = 10;
    localparam int cyclesPerLine = 40;   // longest instruction is 38
    localparam int watchdogSlack = 30;

    typedef struct packed {
        logic [`CU_OP_W-1:0]    opcode;
        logic [`CU_FUNCT_W-1:0] funct;
        logic [4:0]             flags;   // GT LT ET O Div0
        int                     cycles;  // 0 for break
        int                     regWrites;
        int                     regData;
        int                     pcSrc;
        int                     epcWrites;
        int                     memWrites;
    } traceLine_t;

    logic                   clock;
    logic                   RESET_in;
    logic [`CU_OP_W-1:0]    opcode;
    logic [`CU_FUNCT_W-1:0] funct;
    logic                   GT, LT, ET, O, Div0;
    logic RESET_out, BREAK, PCwrite, MemWR, IRwrite, RegWrite, MultOp, DivOp;
    logic EPCwrite, ALUoutW, AW, BW, HIW, LOW, MemDataW;
    logic IorD, ALUsrcA, ALUtoReg, MorDHI, MorDLO;
    logic [1:0]             RegDst;
    logic [1:0]             ALUsrcB;
    logic [2:0]             ALUop;
    logic [2:0]             PCsrc;
    logic [3:0]             RegData;

    traceLine_t trace[$];
    bit         traceLoaded = 1'b0;
    int         errorCount  = 0;
    int         checkCount  = 0;
    int         cycleCount, regWriteCount, lastRegData, lastPcSrc;
    int         epcCount, memWrCount, hiCount, loCount;
    int         routineSel, lastAluOp, aluToRegCount, dataAccessCount, hiSel, loSel;

    controlUnit DUT (
        .clock(clock), .RESET_in(RESET_in), .opcode(opcode), .funct(funct),
        .GT(GT), .LT(LT), .ET(ET), .O(O), .Div0(Div0),
        .RESET_out(RESET_out), .BREAK(BREAK), .PCwrite(PCwrite), .MemWR(MemWR),
        .IRwrite(IRwrite), .RegWrite(RegWrite), .MultOp(MultOp), .DivOp(DivOp),
        .EPCwrite(EPCwrite), .ALUoutW(ALUoutW), .AW(AW), .BW(BW), .HIW(HIW), .LOW(LOW),
        .MemDataW(MemDataW), .IorD(IorD), .ALUsrcA(ALUsrcA), .ALUtoReg(ALUtoReg),
        .MorDHI(MorDHI), .MorDLO(MorDLO), .RegDst(RegDst), .ALUsrcB(ALUsrcB),
        .ALUop(ALUop), .PCsrc(PCsrc), .RegData(RegData)
    );

    initial begin
        clock = 1'b0;
        forever #(clockPeriod / 2) clock = ~clock;
    end

    task automatic checkValue(string testName, int expected, int actual);
        checkCount++;
        assert (actual == expected) else begin
            $display("FAILED %s: expected %0d, actual %0d", testName, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkCondition(bit ok, string problem);
        checkCount++;
        assert (ok) else begin
            $display("ERROR: %s", problem);
            errorCount++;
        end
    endtask

    // ALU code of an ALU instruction, -1 for anything else
    function automatic int aluCodeFor(logic [`CU_OP_W-1:0] op, logic [`CU_FUNCT_W-1:0] fn);
        if (op == `CU_OP_RTYPE) begin
            case (fn)
                `CU_FN_ADD: return 1;
                `CU_FN_SUB: return 2;
                `CU_FN_AND: return 3;
                `CU_FN_SLT: return 7;
                default:    return -1;
            endcase
        end
        case (op)
            `CU_OP_ADDI, `CU_OP_ADDIU: return 1;
            `CU_OP_SLTI:               return 7;
            default:                   return -1;
        endcase
    endfunction

    task automatic loadTrace();
        int         fd;
        int         fields;
        string      line;
        traceLine_t entry;
        int         op, fn, gt, lt, et, ov, d0;
        fd = $fopen("controlUnit_trace.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open controlUnit_trace.txt");
            errorCount++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;   // blank or header
            fields = $sscanf(line, "%h %h %b %b %b %b %b %d %d %b %b %d %d", op, fn,
                             gt, lt, et, ov, d0, entry.cycles, entry.regWrites,
                             entry.regData, entry.pcSrc, entry.epcWrites, entry.memWrites);
            if (fields != 13) begin
                $display("ERROR: malformed trace line: %s", line);
                errorCount++;
                continue;
            end
            entry.opcode = op[`CU_OP_W-1:0];
            entry.funct  = fn[`CU_FUNCT_W-1:0];
            entry.flags  = {gt[0], lt[0], et[0], ov[0], d0[0]};
            trace.push_back(entry);
        end
        $fclose(fd);
    endtask

    task automatic clearTally();
        cycleCount      = 0;
        regWriteCount   = 0;
        lastRegData     = 0;
        lastPcSrc       = 0;
        epcCount        = 0;
        memWrCount      = 0;
        hiCount         = 0;
        loCount         = 0;
        routineSel      = -1;
        lastAluOp       = -1;
        aluToRegCount   = 0;
        dataAccessCount = 0;
        hiSel           = 0;
        loSel           = 0;
    endtask

    // called at the falling edge when outputs have settled
    task automatic tallyCycle();
        cycleCount++;
        if (RegWrite) begin
            regWriteCount++;
            lastRegData = int'(RegData);
        end
        if (PCwrite) begin
            if (epcCount > 0 && routineSel < 0) routineSel = int'(PCsrc);
            lastPcSrc = int'(PCsrc);
        end
        if (EPCwrite) epcCount++;
        if (MemWR) memWrCount++;
        if (ALUoutW) lastAluOp = int'(ALUop);
        if (ALUtoReg) aluToRegCount++;
        if (IorD) dataAccessCount++;
        if (HIW) begin
            hiCount++;
            hiSel = int'(MorDHI);
        end
        if (LOW) begin
            loCount++;
            loSel = int'(MorDLO);
        end
    endtask

    task automatic checkReset();
        int fetchCycles;
        repeat (resetCycles) begin
            @(negedge clock);
            checkCondition(RESET_out === 1'b1, "RESET_out low while reset is held");
            checkCondition({BREAK, PCwrite, MemWR, IRwrite, RegWrite, MultOp, DivOp,
                            EPCwrite, ALUoutW, AW, BW, HIW, LOW, MemDataW} === '0,
                           "a pulse output is active during reset");
        end
        @(posedge clock);
        RESET_in <= 1'b0;
        @(negedge clock);
        checkValue("reset RESET_out after release", 1, int'(RESET_out));
        @(negedge clock);
        checkValue("reset RESET_out cleared", 0, int'(RESET_out));
        checkValue("reset RegWrite", 1, int'(RegWrite));
        checkValue("reset RegDst", 2, int'(RegDst));    // stack pointer
        checkValue("reset RegData", 0, int'(RegData));
        fetchCycles = 0;
        do begin
            @(negedge clock);
            fetchCycles++;
        end while (!IRwrite && fetchCycles < cyclesPerLine);
        checkValue("reset to first IRwrite", 3, fetchCycles);
    endtask

    task automatic runInstruction(int idx);
        traceLine_t t;
        string      name;
        bit         breakSeen;
        bit         irAfterBreak;
        int         expOp;
        int         expSel;
        t    = trace[idx];
        name = $sformatf("line %0d (%h/%h)", idx, t.opcode, t.funct);
        clearTally();
        tallyCycle();                      // the IRwrite cycle itself
        @(posedge clock);
        opcode <= t.opcode;
        funct  <= t.funct;
        {GT, LT, ET, O, Div0} <= t.flags;
        if (t.cycles == 0) begin
            breakSeen    = 1'b0;
            irAfterBreak = 1'b0;
            repeat (cyclesPerLine) begin
                @(negedge clock);
                breakSeen    = breakSeen | BREAK;
                irAfterBreak = irAfterBreak | IRwrite;
            end
            checkCondition(breakSeen, "BREAK never went high after the break instruction");
            checkCondition(!irAfterBreak, "IRwrite pulsed after the break instruction");
            return;
        end
        do begin
            @(negedge clock);
            if (!IRwrite) tallyCycle();
        end while (!IRwrite);
        expOp  = aluCodeFor(t.opcode, t.funct);
        // routine select 111 for divide by zero, 110 for overflow, 101 otherwise
        expSel = (t.epcWrites == 0) ? -1 : (t.flags[0] ? 7 : (t.flags[1] ? 6 : 5));
        checkValue({name, " cycles"}, t.cycles, cycleCount);
        checkValue({name, " RegWrite pulses"}, t.regWrites, regWriteCount);
        checkValue({name, " last RegData"}, t.regData, lastRegData);
        checkValue({name, " last PCsrc"}, t.pcSrc, lastPcSrc);
        checkValue({name, " EPCwrite pulses"}, t.epcWrites, epcCount);
        checkValue({name, " MemWR pulses"}, t.memWrites, memWrCount);
        // only a completed mult or div runs 38 cycles and writes HI/LO
        checkValue({name, " HIW pulses"}, (t.cycles == 38) ? 1 : 0, hiCount);
        checkValue({name, " LOW pulses"}, (t.cycles == 38) ? 1 : 0, loCount);
        checkValue({name, " routine select"}, expSel, routineSel);
        if (expOp >= 0) begin
            checkValue({name, " ALUop"}, expOp, lastAluOp);
        end
        checkValue({name, " ALUtoReg pulses"}, (expOp == 7) ? 1 : 0, aluToRegCount);
        checkValue({name, " IorD cycles"},
                   (t.opcode == `CU_OP_LW || t.opcode == `CU_OP_SW) ? 1 : 0,
                   dataAccessCount);
        if (t.cycles == 38) begin
            checkValue({name, " MorDHI"}, (t.funct == `CU_FN_DIV) ? 1 : 0, hiSel);
            checkValue({name, " MorDLO"}, (t.funct == `CU_FN_DIV) ? 1 : 0, loSel);
        end
    endtask

    initial begin
        int limit;
        wait (traceLoaded);
        limit = trace.size() * cyclesPerLine + watchdogSlack;
        repeat (limit) @(posedge clock);
        $display("ERROR: timeout, run did not finish within %0d cycles", limit);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        RESET_in <= 1'b1;
        opcode   <= '0;
        funct    <= '0;
        {GT, LT, ET, O, Div0} <= '0;
        loadTrace();
        traceLoaded = 1'b1;
        checkReset();
        for (int i = 0; i < trace.size(); i++) begin
            runInstruction(i);
        end
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checkCount, errorCount, DUT.protocolChecks.violationCount);
        if (errorCount == 0 && DUT.protocolChecks.violationCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- controlUnit_asserts.sv
`timescale 1ns/100ps

module controlUnit_asserts (
    input logic clock,
    input logic RESET_in,
    input logic IRwrite,
    input logic PCwrite,
    input logic RegWrite,
    input logic MemWR,
    input logic BREAK
);

    int violationCount = 0;   // failed property count

    irLoadsPc: assert property (
        @(posedge clock) disable iff (RESET_in) IRwrite |-> PCwrite
    ) else begin
        $error("IRwrite pulsed without PCwrite");
        violationCount++;
    end

    // register file and memory never written in the same cycle
    noRegAndMemWrite: assert property (
        @(posedge clock) disable iff (RESET_in) !(RegWrite && MemWR)
    ) else begin
        $error("RegWrite and MemWR high together");
        violationCount++;
    end

    breakHolds: assert property (
        @(posedge clock) disable iff (RESET_in) BREAK |=> BREAK
    ) else begin
        $error("BREAK dropped while reset was low");
        violationCount++;
    end

endmodule

bind controlUnit controlUnit_asserts protocolChecks (
    .clock    (clock),
    .RESET_in (RESET_in),
    .IRwrite  (IRwrite),
    .PCwrite  (PCwrite),
    .RegWrite (RegWrite),
    .MemWR    (MemWR),
    .BREAK    (BREAK)
);

//--- controlUnit.sv
`timescale 1ns/100ps
`include "cuCfg_cfg.svh"

module controlUnit import cuPkg::*; (
    input  logic                   clock,
    input  logic                   RESET_in,
    input  logic [`CU_OP_W-1:0]    opcode,
    input  logic [`CU_FUNCT_W-1:0] funct,
    input  logic                   GT,
    input  logic                   LT,
    input  logic                   ET,
    input  logic                   O,
    input  logic                   Div0,
    output logic                   RESET_out,
    output logic                   BREAK,
    output logic                   PCwrite,
    output logic                   MemWR,
    output logic                   IRwrite,
    output logic                   RegWrite,
    output logic                   MultOp,
    output logic                   DivOp,
    output logic                   EPCwrite,
    output logic                   ALUoutW,
    output logic                   AW,
    output logic                   BW,
    output logic                   HIW,
    output logic                   LOW,
    output logic                   MemDataW,
    output logic                   IorD,
    output logic                   ALUsrcA,
    output logic                   ALUtoReg,
    output logic                   MorDHI,
    output logic                   MorDLO,
    output logic [1:0]             RegDst,
    output logic [1:0]             ALUsrcB,
    output logic [2:0]             ALUop,
    output logic [2:0]             PCsrc,
    output logic [3:0]             RegData
);

    cuState_t   state;
    trapCause_t trapCause;
    aluFunc_t   aluOpEnc;   // typed ALU code from encoder

    decodeIf decBus ();

    assign ALUop = aluOpEnc;

    instrDecoder decoder (
        .opcode (opcode),
        .funct  (funct),
        .dec    (decBus.source)
    );

    stateSequencer sequencer (
        .clock     (clock),
        .RESET_in  (RESET_in),
        .dec       (decBus.sink),
        .GT        (GT),
        .LT        (LT),
        .ET        (ET),
        .O         (O),
        .Div0      (Div0),
        .state     (state),
        .trapCause (trapCause)
    );

    controlEncoder encoder (
        .state     (state),
        .dec       (decBus.sink),
        .trapCause (trapCause),
        .RESET_out (RESET_out),
        .BREAK     (BREAK),
        .PCwrite   (PCwrite),
        .MemWR     (MemWR),
        .IRwrite   (IRwrite),
        .RegWrite  (RegWrite),
        .MultOp    (MultOp),
        .DivOp     (DivOp),
        .EPCwrite  (EPCwrite),
        .ALUoutW   (ALUoutW),
        .AW        (AW),
        .BW        (BW),
        .HIW       (HIW),
        .LOW       (LOW),
        .MemDataW  (MemDataW),
        .IorD      (IorD),
        .ALUsrcA   (ALUsrcA),
        .ALUtoReg  (ALUtoReg),
        .MorDHI    (MorDHI),
        .MorDLO    (MorDLO),
        .RegDst    (RegDst),
        .ALUsrcB   (ALUsrcB),
        .ALUop     (aluOpEnc),
        .PCsrc     (PCsrc),
        .RegData   (RegData)
    );

endmodule

//--- controlEncoder.sv
`timescale 1ns/100ps

module controlEncoder import cuPkg::*; (
    input  cuState_t    state,
    decodeIf.sink       dec,
    input  trapCause_t  trapCause,
    output logic        RESET_out,
    output logic        BREAK,
    output logic        PCwrite,
    output logic        MemWR,
    output logic        IRwrite,
    output logic        RegWrite,
    output logic        MultOp,
    output logic        DivOp,
    output logic        EPCwrite,
    output logic        ALUoutW,
    output logic        AW,
    output logic        BW,
    output logic        HIW,
    output logic        LOW,
    output logic        MemDataW,
    output logic        IorD,
    output logic        ALUsrcA,
    output logic        ALUtoReg,
    output logic        MorDHI,
    output logic        MorDLO,
    output logic [1:0]  RegDst,
    output logic [1:0]  ALUsrcB,
    output aluFunc_t    ALUop,
    output logic [2:0]  PCsrc,
    output logic [3:0]  RegData
);

    logic [2:0] routinePc;   // handler vector select
    logic       divResult;

    assign routinePc = (trapCause == trapDivZero)  ? 3'b111 :
                       (trapCause == trapOverflow) ? 3'b110 : 3'b101;
    assign divResult = (dec.instClass == clsDiv);

    always_comb begin
        {RESET_out, BREAK, PCwrite, MemWR, IRwrite, RegWrite, MultOp, DivOp} = '0;
        {EPCwrite, ALUoutW, AW, BW, HIW, LOW, MemDataW} = '0;
        {IorD, ALUsrcA, ALUtoReg, MorDHI, MorDLO} = '0;
        RegDst  = 2'b00;
        ALUsrcB = 2'b00;
        ALUop   = aluPass;
        PCsrc   = 3'b000;
        RegData = 4'b0000;
        case (state)
            stReset:   RESET_out = 1'b1;
            stResetSp: begin
                RegDst   = 2'b10;   // sp, RegData 0000
                RegWrite = 1'b1;
            end
            stBrk:     BREAK = 1'b1;
            stPcRead, stInstWrite: begin
                ALUsrcB = 2'b01;    // PC+4
                ALUop   = aluAdd;
                IRwrite = (state == stInstWrite);
                PCwrite = (state == stInstWrite);
            end
            stInstDec: begin
                AW      = 1'b1;
                BW      = 1'b1;
                ALUsrcB = 2'b11;    // branch offset
                ALUop   = aluAdd;
                ALUoutW = 1'b1;
            end
            stMemAdd: begin
                ALUsrcA = 1'b1;
                ALUsrcB = 2'b10;
                ALUop   = aluAdd;
                ALUoutW = 1'b1;
            end
            stMemRead:  IorD = 1'b1;
            stMemDataW: MemDataW = 1'b1;
            stMemWrite: begin
                IorD  = 1'b1;
                MemWR = 1'b1;
            end
            stMemToReg, stLoadImm, stLoadHi, stLoadLo, stAluToReg: begin
                RegWrite = 1'b1;
                case (state)
                    stMemToReg: RegData = 4'b0001;
                    stLoadImm:  RegData = 4'b1000;
                    stLoadHi:   RegData = 4'b0011;
                    stLoadLo:   RegData = 4'b0100;
                    default:    RegData = 4'b0010;
                endcase
                // rd only for R-type results
                RegDst = (state == stLoadHi || state == stLoadLo ||
                          (state == stAluToReg && !dec.immToRt)) ? 2'b01 : 2'b00;
            end
            stJump, stAluToPc, stEpcToPc, stRoutineToPc: begin
                PCwrite = 1'b1;
                case (state)
                    stJump:    PCsrc = 3'b010;
                    stAluToPc: PCsrc = 3'b001;
                    stEpcToPc: PCsrc = 3'b011;
                    default:   PCsrc = 3'b100;
                endcase
            end
            stStorePc:  ALUoutW = 1'b1;   // PC passes through ALU
            stJumpSave: begin
                PCsrc    = 3'b010;
                PCwrite  = 1'b1;
                RegData  = 4'b0010;
                RegDst   = 2'b11;
                RegWrite = 1'b1;
            end
            stPcToEpc: begin
                ALUsrcB  = 2'b01;   // undo PC+4
                ALUop    = aluSub;
                EPCwrite = 1'b1;
                PCsrc    = routinePc;
            end
            stRoutineSel: begin
                PCsrc   = routinePc;
                PCwrite = 1'b1;
            end
            stCompare: begin
                ALUsrcA = 1'b1;
                ALUop   = aluCompare;
            end
            stAluJumpToPc: begin
                ALUsrcA = 1'b1;     // rs straight to PC
                PCwrite = 1'b1;
            end
            stAluOp: begin
                ALUsrcA  = 1'b1;
                ALUsrcB  = dec.immToRt ? 2'b10 : 2'b00;
                ALUop    = dec.aluFunc;
                ALUtoReg = (dec.aluFunc == aluCompare);   // slt/slti flag result
                ALUoutW  = 1'b1;
            end
            stDivIter:  DivOp = 1'b1;
            stMultIter: MultOp = 1'b1;
            stWriteHiLo: begin
                MorDHI = divResult;
                MorDLO = divResult;
                HIW    = 1'b1;
                LOW    = 1'b1;
            end
            default: ;   // memory wait and routine read drive nothing
        endcase
    end

endmodule

//--- stateSequencer.sv
`timescale 1ns/100ps
`include "cuCfg_cfg.svh"

module stateSequencer import cuPkg::*; (
    input  logic       clock,
    input  logic       RESET_in,
    decodeIf.sink      dec,
    input  logic       GT,
    input  logic       LT,
    input  logic       ET,
    input  logic       O,
    input  logic       Div0,
    output cuState_t   state,
    output trapCause_t trapCause
);

    cuState_t               nextState;
    cuState_t               retState;      // where stMemWait goes next
    trapCause_t             enterCause;    // non-none only on trap entry
    logic [`CU_ITER_W-1:0]  iterCount;
    logic                   iterating;
    logic                   branchTaken;

    assign iterating = (state == stMultIter) || (state == stDivIter);

    always_comb begin
        case (dec.branchCond)
            brEq:    branchTaken = ET;
            brNe:    branchTaken = !ET;
            brGt:    branchTaken = GT;
            default: branchTaken = LT || ET;   // ble
        endcase
    end

    always_comb begin
        enterCause = trapNone;
        case (state)
            stReset:     nextState = stResetSp;
            stResetSp:   nextState = stPcRead;
            stBrk:       nextState = stBrk;
            stPcRead:    nextState = stMemWait;
            stMemWait:   nextState = retState;
            stInstWrite: nextState = stInstDec;
            stInstDec: begin
                case (dec.instClass)
                    clsAluReg, clsAluImm: nextState = stAluOp;
                    clsBranch:            nextState = stCompare;
                    clsLoad, clsStore:    nextState = stMemAdd;
                    clsJump:              nextState = stJump;
                    clsJumpLink:          nextState = stStorePc;
                    clsJumpReg:           nextState = stAluJumpToPc;
                    clsLoadUpper:         nextState = stLoadImm;
                    clsMoveHi:            nextState = stLoadHi;
                    clsMoveLo:            nextState = stLoadLo;
                    clsReturnExc:         nextState = stEpcToPc;
                    clsMult:              nextState = stMultIter;
                    clsDiv:               nextState = stDivIter;
                    clsBrk:               nextState = stBrk;
                    default: begin
                        nextState  = stPcToEpc;
                        enterCause = trapIllegal;
                    end
                endcase
            end
            stMemAdd:   nextState = (dec.instClass == clsStore) ? stMemWrite : stMemRead;
            stMemRead:  nextState = stMemWait;
            stMemDataW: nextState = (dec.instClass == clsLoad) ? stMemToReg : stRoutineToPc;
            stStorePc:  nextState = stJumpSave;
            stCompare:  nextState = branchTaken ? stAluToPc : stPcRead;
            stAluOp: begin
                if (dec.checksOverflow && O) begin
                    nextState  = stPcToEpc;
                    enterCause = trapOverflow;
                end else begin
                    nextState = stAluToReg;
                end
            end
            stMultIter: nextState = (iterCount == `CU_ITER_LAST) ? stWriteHiLo : stMultIter;
            stDivIter: begin
                if (Div0 && iterCount == '0) begin   // divisor checked on first pass
                    nextState  = stPcToEpc;
                    enterCause = trapDivZero;
                end else begin
                    nextState = (iterCount == `CU_ITER_LAST) ? stWriteHiLo : stDivIter;
                end
            end
            stPcToEpc:     nextState = stRoutineSel;
            stRoutineSel:  nextState = stGoToRoutine;
            stGoToRoutine: nextState = stMemWait;
            default:       nextState = stPcRead;   // last execute cycle, back to fetch
        endcase
    end

    always_ff @(posedge clock or posedge RESET_in) begin
        if (RESET_in) begin
            state     <= stReset;
            retState  <= stInstWrite;
            iterCount <= '0;
            trapCause <= trapNone;
        end else begin
            state <= nextState;
            if (state == stPcRead) begin
                retState <= stInstWrite;
            end else if (state == stMemRead || state == stGoToRoutine) begin
                retState <= stMemDataW;
            end
            iterCount <= iterating ? iterCount + 1'b1 : '0;
            if (enterCause != trapNone) begin
                trapCause <= enterCause;
            end
        end
    end

endmodule

//--- instrDecoder.sv
`timescale 1ns/100ps
`include "cuCfg_cfg.svh"

module instrDecoder import cuPkg::*; (
    input  logic [`CU_OP_W-1:0]    opcode,
    input  logic [`CU_FUNCT_W-1:0] funct,
    decodeIf.source                dec
);

    always_comb begin
        dec.instClass = clsIllegal;   // anything unmatched traps
        case (opcode)
            `CU_OP_RTYPE: begin
                case (funct)
                    `CU_FN_ADD, `CU_FN_SUB, `CU_FN_AND, `CU_FN_SLT: dec.instClass = clsAluReg;
                    `CU_FN_JR:    dec.instClass = clsJumpReg;
                    `CU_FN_BREAK: dec.instClass = clsBrk;
                    `CU_FN_MFHI:  dec.instClass = clsMoveHi;
                    `CU_FN_MFLO:  dec.instClass = clsMoveLo;
                    `CU_FN_RTE:   dec.instClass = clsReturnExc;
                    `CU_FN_MULT:  dec.instClass = clsMult;
                    `CU_FN_DIV:   dec.instClass = clsDiv;
                    default:      dec.instClass = clsIllegal;
                endcase
            end
            `CU_OP_ADDI, `CU_OP_ADDIU, `CU_OP_SLTI: dec.instClass = clsAluImm;
            `CU_OP_BEQ, `CU_OP_BNE, `CU_OP_BLE, `CU_OP_BGT: dec.instClass = clsBranch;
            `CU_OP_LW:  dec.instClass = clsLoad;
            `CU_OP_SW:  dec.instClass = clsStore;
            `CU_OP_J:   dec.instClass = clsJump;
            `CU_OP_JAL: dec.instClass = clsJumpLink;
            `CU_OP_LUI: dec.instClass = clsLoadUpper;
            default:    dec.instClass = clsIllegal;
        endcase
    end

    always_comb begin
        dec.aluFunc = aluPass;
        if (opcode == `CU_OP_RTYPE) begin
            case (funct)
                `CU_FN_ADD: dec.aluFunc = aluAdd;
                `CU_FN_SUB: dec.aluFunc = aluSub;
                `CU_FN_AND: dec.aluFunc = aluAnd;
                `CU_FN_SLT: dec.aluFunc = aluCompare;
                default:    dec.aluFunc = aluPass;
            endcase
        end else if (opcode == `CU_OP_ADDI || opcode == `CU_OP_ADDIU) begin
            dec.aluFunc = aluAdd;
        end else if (opcode == `CU_OP_SLTI) begin
            dec.aluFunc = aluCompare;
        end
    end

    always_comb begin
        case (opcode)
            `CU_OP_BNE: dec.branchCond = brNe;
            `CU_OP_BGT: dec.branchCond = brGt;
            `CU_OP_BLE: dec.branchCond = brLe;
            default:    dec.branchCond = brEq;
        endcase
    end

    // addiu never traps
    assign dec.checksOverflow = (opcode == `CU_OP_ADDI) ||
                                (dec.instClass == clsAluReg &&
                                 (dec.aluFunc == aluAdd || dec.aluFunc == aluSub));
    assign dec.immToRt = (dec.instClass == clsAluImm);

endmodule

//--- decodeIf.sv
`timescale 1ns/100ps

interface decodeIf import cuPkg::*; ();
    instrClass_t instClass;
    aluFunc_t    aluFunc;
    branchCond_t branchCond;
    logic        checksOverflow;   // add, sub, addi only
    logic        immToRt;          // I-type result goes to rt

    modport source (
        output instClass, aluFunc, branchCond, checksOverflow, immToRt
    );

    modport sink (
        input instClass, aluFunc, branchCond, checksOverflow, immToRt
    );
endinterface

//--- cuPkg.sv
package cuPkg;

`include "cuCfg_cfg.svh"

    typedef enum logic [`CU_STATE_W-1:0] {
        stReset,        // drives RESET_out
        stResetSp,      // stack pointer init
        stBrk,          // halted until reset
        stPcRead,       // fetch address out, PC+4 in ALU
        stMemWait,      // shared memory wait
        stInstWrite,    // IR and PC load
        stInstDec,      // A/B load, branch target
        stMemAdd,
        stMemRead,
        stMemDataW,
        stMemWrite,
        stMemToReg,
        stJump,
        stStorePc,      // return address into ALUout
        stJumpSave,
        stPcToEpc,      // first exception entry cycle
        stRoutineSel,
        stGoToRoutine,
        stRoutineToPc,
        stLoadImm,
        stEpcToPc,
        stLoadLo,
        stLoadHi,
        stCompare,
        stAluToPc,
        stAluJumpToPc,
        stAluOp,
        stAluToReg,
        stDivIter,
        stMultIter,
        stWriteHiLo
    } cuState_t;

    typedef enum logic [3:0] {
        clsAluReg, clsAluImm, clsBranch, clsLoad,
        clsStore, clsJump, clsJumpLink, clsJumpReg,
        clsLoadUpper, clsMoveHi, clsMoveLo, clsReturnExc,
        clsMult, clsDiv, clsBrk, clsIllegal
    } instrClass_t;

    typedef enum logic [2:0] {
        aluPass    = 3'b000,
        aluAdd     = 3'b001,
        aluSub     = 3'b010,
        aluAnd     = 3'b011,
        aluCompare = 3'b111
    } aluFunc_t;

    typedef enum logic [1:0] {brEq, brNe, brGt, brLe} branchCond_t;

    typedef enum logic [1:0] {trapNone, trapOverflow, trapDivZero, trapIllegal} trapCause_t;

endpackage

//--- cuCfg_cfg.svh
`ifndef CU_CFG_SVH
`define CU_CFG_SVH

`define CU_OP_W         6
`define CU_FUNCT_W      6
`define CU_STATE_W      6
`define CU_ITER_W       6
`define CU_ITER_LAST    6'd32   // 33 iteration cycles for mult/div

`define CU_OP_RTYPE     6'h00
`define CU_OP_J         6'h02
`define CU_OP_JAL       6'h03
`define CU_OP_BEQ       6'h04
`define CU_OP_BNE       6'h05
`define CU_OP_BLE       6'h06
`define CU_OP_BGT       6'h07
`define CU_OP_ADDI      6'h08
`define CU_OP_ADDIU     6'h09
`define CU_OP_SLTI      6'h0a
`define CU_OP_LUI       6'h0f
`define CU_OP_LW        6'h23
`define CU_OP_SW        6'h2b

`define CU_FN_JR        6'h08
`define CU_FN_BREAK     6'h0d
`define CU_FN_MFHI      6'h10
`define CU_FN_MFLO      6'h12
`define CU_FN_RTE       6'h13
`define CU_FN_MULT      6'h18
`define CU_FN_DIV       6'h1a
`define CU_FN_ADD       6'h20
`define CU_FN_SUB       6'h22
`define CU_FN_AND       6'h24
`define CU_FN_SLT       6'h2a

`endif
